// ==== project.f ====
+incdir+.
usb_mem_pkg.sv
axis_byte_packer.sv
axis_packet_store.sv
axis_byte_unpacker.sv
status_leds.sv
usb_mem_top.sv
tb_usb_mem_top.sv

// ==== tb_usb_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "usb_mem_settings.svh"

module tb_usb_mem_top;

  localparam int MAX_BYTES = `USB_MEM_STORE_WORDS * 4;  // Longest packet the store keeps
  localparam int NUM_PKTS  = 30;

  logic clock, reset, configured;
  logic blko_tvalid, blko_tlast, blko_tready;
  logic blki_tvalid, blki_tlast, blki_tready;
  usb_mem_pkg::usb_byte_t blko_tdata, blki_tdata;
  logic [5:0] leds;

  // Reference model with one entry per BULK IN byte of the kept packets
  usb_mem_pkg::usb_byte_t exp_data [$];
  logic                   exp_last [$];
  usb_mem_pkg::usb_byte_t cur_pkt [$];
  int  pkt_len [NUM_PKTS];
  int  total_bytes, kept_count, rx_count;
  bit  drv_done, ovf_expected, held;
  bit  rx_act, tx_act;  // Byte transfers seen in the previous cycle
  usb_mem_pkg::usb_byte_t held_data, next_byte;
  logic held_last;

  usb_mem_top dut (
    .clock_i(clock), .reset_i(reset), .configured_i(configured),
    .blko_tvalid_i(blko_tvalid), .blko_tlast_i(blko_tlast),
    .blko_tdata_i(blko_tdata), .blko_tready_o(blko_tready),
    .blki_tvalid_o(blki_tvalid), .blki_tlast_o(blki_tlast),
    .blki_tdata_o(blki_tdata), .blki_tready_i(blki_tready),
    .leds_o(leds)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "Stopped at first error");
  endtask

  // Outputs while the link is down
  task automatic check_quiet();
    assert (!blko_tready && !blki_tvalid && leds == 6'b111111)
      else report_error($sformatf("idle outputs wrong, tready %b tvalid %b leds %b",
                                  blko_tready, blki_tvalid, leds));
  endtask

  // Offer one byte and return once the coming edge will take it
  task automatic send_byte(input usb_mem_pkg::usb_byte_t data, input logic last);
    int gap;
    gap = ($urandom % 4 == 0) ? ($urandom % 3) + 1 : 0;
    repeat (gap) begin
      @(negedge clock);
      blko_tvalid = 1'b0;
    end
    @(negedge clock);
    blko_tvalid = 1'b1;
    blko_tdata  = data;
    blko_tlast  = last;
    #1;
    while (!blko_tready) begin
      @(negedge clock);
      #1;
    end
  endtask

  initial begin
    reset = 1'b1;
    configured = 1'b0;
    blko_tvalid = 1'b0;
    blko_tlast = 1'b0;
    blko_tdata = '0;
    blki_tready = 1'b0;
    void'($urandom(40381));
    total_bytes = 0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      pkt_len[p] = (p == 20) ? 2100 : ($urandom % 300) + 1;
      total_bytes += pkt_len[p];
    end
    fork
      begin
        repeat (total_bytes * 30 + 5000) @(posedge clock);
        $display("Timeout, BULK IN did not return all packets in time");
        $display("sim failed");
        $fatal(1, "Watchdog expired");
      end
    join_none
    repeat (16) begin
      @(negedge clock);
      check_quiet();
    end
    reset = 1'b0;
    repeat (16) begin
      @(negedge clock);
      check_quiet();
    end
    // Offered byte must not be taken while not configured
    blko_tvalid = 1'b1;
    blko_tdata  = 8'h5a;
    repeat (($urandom % 40) + 1) begin
      @(negedge clock);
      #1;
      assert (!blko_tready) else report_error("blko_tready_o high while unconfigured");
    end
    @(negedge clock);
    configured  = 1'b1;
    blko_tvalid = 1'b0;
    #1;
    assert (leds[0] == 1'b0) else report_error("led 0 not lit after configuration");
    fork
      begin
        for (int p = 0; p < NUM_PKTS; p++) begin
          cur_pkt.delete();
          for (int i = 0; i < pkt_len[p]; i++) begin
            next_byte = $urandom % 256;
            send_byte(next_byte, i == pkt_len[p] - 1);
            cur_pkt.push_back(next_byte);
          end
          if (cur_pkt.size() <= MAX_BYTES) begin
            foreach (cur_pkt[i]) begin
              exp_data.push_back(cur_pkt[i]);
              exp_last.push_back(i == cur_pkt.size() - 1);
            end
            kept_count++;
          end
          if (p == 20) ovf_expected = 1'b1;
        end
        @(negedge clock);
        blko_tvalid = 1'b0;
        drv_done = 1'b1;
      end
      begin
        while (!(drv_done && rx_count == kept_count)) begin
          @(negedge clock);
          blki_tready = ($urandom % 4) != 0;
          #1;
          if (held) begin
            assert (blki_tvalid && blki_tdata == held_data && blki_tlast == held_last)
              else report_error("BULK IN byte changed while stalled");
          end
          assert (!rx_act || !leds[4])
            else report_error("led 4 not lit after a BULK OUT byte");
          assert (!tx_act || !leds[5])
            else report_error("led 5 not lit after a BULK IN byte");
          if (blki_tvalid && blki_tready) begin
            assert (exp_data.size() != 0) else report_error("BULK IN byte not expected");
            assert (blki_tdata == exp_data[0] && blki_tlast == exp_last[0])
              else report_error($sformatf("packet %0d got %02h/%b, expected %02h/%b",
                                          rx_count, blki_tdata, blki_tlast,
                                          exp_data[0], exp_last[0]));
            if (blki_tlast) rx_count++;
            void'(exp_data.pop_front());
            void'(exp_last.pop_front());
          end
          held      = blki_tvalid && !blki_tready;
          held_data = blki_tdata;
          held_last = blki_tlast;
          rx_act    = blko_tvalid && blko_tready;
          tx_act    = blki_tvalid && blki_tready;
          assert (!ovf_expected || !leds[3]) else report_error("led 3 off after overflow");
        end
      end
    join
    repeat (`USB_MEM_LED_STRETCH + 8) begin
      @(negedge clock);
      blki_tready = 1'b1;
      #1;
      assert (!blki_tvalid) else report_error("BULK IN byte after the last packet");
    end
    assert (leds[1] && leds[2] && leds[4] && leds[5] && !leds[0] && !leds[3])
      else report_error($sformatf("final leds %b", leds));
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== usb_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module usb_mem_top (
  input  wire logic                   clock_i,
  input  wire logic                   reset_i,
  input  wire logic                   configured_i,
  // BULK OUT from the USB core
  input  wire logic                   blko_tvalid_i,
  input  wire logic                   blko_tlast_i,
  input  wire usb_mem_pkg::usb_byte_t blko_tdata_i,
  output logic                        blko_tready_o,
  // BULK IN to the USB core
  output logic                        blki_tvalid_o,
  output logic                        blki_tlast_o,
  output usb_mem_pkg::usb_byte_t      blki_tdata_o,
  input  wire logic                   blki_tready_i,
  output logic [5:0]                  leds_o
);

  // Packer to store
  logic                    pw_valid;
  logic                    pw_last;
  usb_mem_pkg::mem_word_t  pw_data;
  usb_mem_pkg::byte_keep_t pw_keep;
  logic                    pw_ready;
  // Store to unpacker
  logic                    sw_valid;
  logic                    sw_last;
  usb_mem_pkg::mem_word_t  sw_data;
  usb_mem_pkg::byte_keep_t sw_keep;
  logic                    sw_ready;
  logic                    stored;
  logic                    full;
  logic                    overflow;

  axis_byte_packer u_packer (
    .clock_i(clock_i), .reset_i(reset_i), .configured_i(configured_i),
    .blko_tvalid_i(blko_tvalid_i), .blko_tlast_i(blko_tlast_i),
    .blko_tdata_i(blko_tdata_i), .blko_tready_o(blko_tready_o),
    .pw_valid_o(pw_valid), .pw_last_o(pw_last), .pw_data_o(pw_data),
    .pw_keep_o(pw_keep), .pw_ready_i(pw_ready)
  );

  axis_packet_store u_store (
    .clock_i(clock_i), .reset_i(reset_i),
    .pw_valid_i(pw_valid), .pw_last_i(pw_last), .pw_data_i(pw_data),
    .pw_keep_i(pw_keep), .pw_ready_o(pw_ready),
    .sw_valid_o(sw_valid), .sw_last_o(sw_last), .sw_data_o(sw_data),
    .sw_keep_o(sw_keep), .sw_ready_i(sw_ready),
    .stored_o(stored), .full_o(full), .overflow_o(overflow)
  );

  axis_byte_unpacker u_unpacker (
    .clock_i(clock_i), .reset_i(reset_i),
    .sw_valid_i(sw_valid), .sw_last_i(sw_last), .sw_data_i(sw_data),
    .sw_keep_i(sw_keep), .sw_ready_o(sw_ready),
    .blki_tvalid_o(blki_tvalid_o), .blki_tlast_o(blki_tlast_o),
    .blki_tdata_o(blki_tdata_o), .blki_tready_i(blki_tready_i)
  );

  status_leds u_leds (
    .clock_i(clock_i), .reset_i(reset_i), .configured_i(configured_i),
    .stored_i(stored), .full_i(full), .overflow_i(overflow),
    .blko_tvalid_i(blko_tvalid_i), .blko_tready_i(blko_tready_o),
    .blki_tvalid_i(blki_tvalid_o), .blki_tready_i(blki_tready_i),
    .leds_o(leds_o)
  );

endmodule

`default_nettype wire

// ==== status_leds.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "usb_mem_settings.svh"

module status_leds (
  input  wire logic  clock_i,
  input  wire logic  reset_i,
  input  wire logic  configured_i,
  input  wire logic  stored_i,
  input  wire logic  full_i,
  input  wire logic  overflow_i,
  input  wire logic  blko_tvalid_i,
  input  wire logic  blko_tready_i,
  input  wire logic  blki_tvalid_i,
  input  wire logic  blki_tready_i,
  output logic [5:0] leds_o
);

  localparam int STRETCH_BITS = $clog2(`USB_MEM_LED_STRETCH + 1);
  localparam logic [STRETCH_BITS-1:0] STRETCH_LOAD = STRETCH_BITS'(`USB_MEM_LED_STRETCH);

  logic [1:0]              xfer;          // Bit 0 receive, bit 1 transmit
  logic [STRETCH_BITS-1:0] stretch_q [2];
  logic                    ovf_seen_q;

  assign xfer[0] = blko_tvalid_i & blko_tready_i;
  assign xfer[1] = blki_tvalid_i & blki_tready_i;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stretch_q[0] <= '0;
      stretch_q[1] <= '0;
      ovf_seen_q   <= 1'b0;
    end else begin
      if (overflow_i) begin
        ovf_seen_q <= 1'b1;  // Held until reset
      end
      for (int i = 0; i < 2; i++) begin
        if (xfer[i]) begin
          stretch_q[i] <= STRETCH_LOAD;
        end else if (stretch_q[i] != '0) begin
          stretch_q[i] <= stretch_q[i] - 1'b1;
        end
      end
    end
  end

  // Active low like the dev-board LEDs
  assign leds_o = ~{stretch_q[1] != '0, stretch_q[0] != '0, ovf_seen_q,
                    full_i, stored_i, configured_i};

endmodule

`default_nettype wire

// ==== axis_byte_unpacker.sv ====
`timescale 1ns/10ps
`default_nettype none

module axis_byte_unpacker (
  input  wire logic                    clock_i,
  input  wire logic                    reset_i,
  // Word stream from the store
  input  wire logic                    sw_valid_i,
  input  wire logic                    sw_last_i,
  input  wire usb_mem_pkg::mem_word_t  sw_data_i,
  input  wire usb_mem_pkg::byte_keep_t sw_keep_i,
  output logic                         sw_ready_o,
  // BULK IN bytes to the USB core
  output logic                         blki_tvalid_o,
  output logic                         blki_tlast_o,
  output usb_mem_pkg::usb_byte_t       blki_tdata_o,
  input  wire logic                    blki_tready_i
);

  usb_mem_pkg::mem_word_t  data_q;  // Current byte always in bits 7:0
  usb_mem_pkg::byte_keep_t keep_q;  // Lanes left to send
  logic                    last_q;
  logic                    final_byte;
  logic                    byte_go;
  logic                    word_take;

  assign blki_tvalid_o = keep_q[0];
  assign blki_tdata_o  = data_q[7:0];
  assign final_byte    = ~keep_q[1];
  assign blki_tlast_o  = last_q & keep_q[0] & final_byte;
  assign byte_go       = blki_tvalid_o & blki_tready_i;
  assign sw_ready_o    = ~keep_q[0] | (blki_tready_i & final_byte);
  assign word_take     = sw_valid_i & sw_ready_o;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      keep_q <= '0;
    end else if (word_take) begin
      keep_q <= sw_keep_i;
    end else if (byte_go) begin
      keep_q <= keep_q >> 1;
    end
  end

  // Shift the word down one lane per byte
  always_ff @(posedge clock_i) begin
    if (word_take) begin
      data_q <= sw_data_i;
      last_q <= sw_last_i;
    end else if (byte_go) begin
      data_q <= data_q >> 8;
    end
  end

endmodule

`default_nettype wire

// ==== axis_packet_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "usb_mem_settings.svh"

module axis_packet_store (
  input  wire logic                    clock_i,
  input  wire logic                    reset_i,
  // Word stream from the packer
  input  wire logic                    pw_valid_i,
  input  wire logic                    pw_last_i,
  input  wire usb_mem_pkg::mem_word_t  pw_data_i,
  input  wire usb_mem_pkg::byte_keep_t pw_keep_i,
  output logic                         pw_ready_o,
  // Word stream to the unpacker
  output logic                         sw_valid_o,
  output logic                         sw_last_o,
  output usb_mem_pkg::mem_word_t       sw_data_o,
  output usb_mem_pkg::byte_keep_t      sw_keep_o,
  input  wire logic                    sw_ready_i,
  // Status
  output logic                         stored_o,
  output logic                         full_o,
  output logic                         overflow_o
);

  typedef enum logic {ACCEPT, DISCARD} state_t;

  localparam usb_mem_pkg::store_count_t STORE_WORDS = `USB_MEM_STORE_WORDS;

  usb_mem_pkg::mem_word_t    ram_data [`USB_MEM_STORE_WORDS];
  usb_mem_pkg::byte_keep_t   ram_keep [`USB_MEM_STORE_WORDS];
  logic                      ram_last [`USB_MEM_STORE_WORDS];

  usb_mem_pkg::store_addr_t  wr_ptr;
  usb_mem_pkg::store_addr_t  cm_ptr;     // First word past the last complete packet
  usb_mem_pkg::store_addr_t  rd_ptr;
  usb_mem_pkg::store_count_t used_cnt;   // Words in RAM, committed or not
  usb_mem_pkg::store_count_t unc_cnt;    // Words of the packet still arriving
  usb_mem_pkg::store_count_t avail_cnt;  // Committed words not yet fetched
  state_t                    state_q;
  logic                      pw_take;
  logic                      condemned;  // Whole RAM taken by one open packet
  logic                      wr_en;
  logic                      drop_now;
  logic                      rd_fetch;

  assign condemned  = (unc_cnt == STORE_WORDS);
  assign full_o     = (used_cnt == STORE_WORDS) && !condemned;
  assign pw_ready_o = ~full_o;
  assign pw_take    = pw_valid_i & pw_ready_o;
  assign wr_en      = pw_take && (state_q == ACCEPT) && !condemned;
  assign drop_now   = pw_take && (state_q == ACCEPT) && condemned;
  assign avail_cnt  = used_cnt - unc_cnt;
  assign rd_fetch   = (avail_cnt != '0) && (!sw_valid_o || sw_ready_i);
  assign stored_o   = sw_valid_o || (avail_cnt != '0);

  // Write side and oversize handling
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q    <= ACCEPT;
      wr_ptr     <= '0;
      cm_ptr     <= '0;
      unc_cnt    <= '0;
      overflow_o <= 1'b0;
    end else begin
      overflow_o <= drop_now;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (pw_last_i) begin
          cm_ptr  <= wr_ptr + 1'b1;  // Release the packet to the reader
          unc_cnt <= '0;
        end else begin
          unc_cnt <= unc_cnt + 1'b1;
        end
      end
      if (drop_now) begin
        wr_ptr  <= cm_ptr;  // Rewind over the oversize packet
        unc_cnt <= '0;
        if (!pw_last_i) begin
          state_q <= DISCARD;
        end
      end
      if (pw_take && (state_q == DISCARD) && pw_last_i) begin
        state_q <= ACCEPT;
      end
    end
  end

  // Read side with the RAM output as prefetch register
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      rd_ptr     <= '0;
      used_cnt   <= '0;
      sw_valid_o <= 1'b0;
    end else begin
      used_cnt <= used_cnt + usb_mem_pkg::store_count_t'(wr_en)
                - usb_mem_pkg::store_count_t'(rd_fetch)
                - (drop_now ? unc_cnt : '0);
      if (rd_fetch) begin
        rd_ptr     <= rd_ptr + 1'b1;
        sw_valid_o <= 1'b1;
      end else if (sw_ready_i) begin
        sw_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (wr_en) begin
      ram_data[wr_ptr] <= pw_data_i;
      ram_keep[wr_ptr] <= pw_keep_i;
      ram_last[wr_ptr] <= pw_last_i;
    end
    if (rd_fetch) begin
      sw_data_o <= ram_data[rd_ptr];
      sw_keep_o <= ram_keep[rd_ptr];
      sw_last_o <= ram_last[rd_ptr];
    end
  end

  // A write never lands on a word that is still unread
  assert property (@(posedge clock_i) disable iff (reset_i)
    wr_en |-> (wr_ptr != rd_ptr) || (used_cnt == '0));

  // With nothing committed left the reader sits exactly on the commit point
  assert property (@(posedge clock_i) disable iff (reset_i)
    (avail_cnt == '0) |-> (rd_ptr == cm_ptr));

endmodule

`default_nettype wire

// ==== axis_byte_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module axis_byte_packer (
  input  wire logic                   clock_i,
  input  wire logic                   reset_i,
  input  wire logic                   configured_i,
  // BULK OUT bytes from the USB core
  input  wire logic                   blko_tvalid_i,
  input  wire logic                   blko_tlast_i,
  input  wire usb_mem_pkg::usb_byte_t blko_tdata_i,
  output logic                        blko_tready_o,
  // Packed words towards the store
  output logic                        pw_valid_o,
  output logic                        pw_last_o,
  output usb_mem_pkg::mem_word_t      pw_data_o,
  output usb_mem_pkg::byte_keep_t     pw_keep_o,
  input  wire logic                   pw_ready_i
);

  logic [1:0] lane_q;     // Next byte lane to fill
  logic       word_take;
  logic       byte_take;
  logic       word_done;  // Current byte closes the word

  assign word_take     = pw_valid_o & pw_ready_i;
  assign blko_tready_o = configured_i & (~pw_valid_o | pw_ready_i);
  assign byte_take     = blko_tvalid_i & blko_tready_o;
  assign word_done     = blko_tlast_i | (lane_q == 2'd3);

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pw_valid_o <= 1'b0;
      lane_q     <= 2'd0;
    end else if (byte_take && word_done) begin
      pw_valid_o <= 1'b1;  // Offered in the next cycle
      lane_q     <= 2'd0;
    end else begin
      if (word_take) begin
        pw_valid_o <= 1'b0;
      end
      if (byte_take) begin
        lane_q <= lane_q + 2'd1;
      end
    end
  end

  // Word assembly
  always_ff @(posedge clock_i) begin
    if (byte_take) begin
      if (lane_q == 2'd0) begin
        pw_data_o <= {24'd0, blko_tdata_i};  // Unfilled lanes read as zero
        pw_keep_o <= 4'b0001;
      end else begin
        pw_data_o[lane_q*8 +: 8] <= blko_tdata_i;
        pw_keep_o                <= {pw_keep_o[2:0], 1'b1};
      end
      pw_last_o <= blko_tlast_i;
    end
  end

  // A stalled word stays offered and unchanged until the store takes it
  assert property (@(posedge clock_i) disable iff (reset_i)
    pw_valid_o && !pw_ready_i |=>
      pw_valid_o && $stable(pw_data_o) && $stable(pw_keep_o) && $stable(pw_last_o));

endmodule

`default_nettype wire

// ==== usb_mem_pkg.sv ====
`default_nettype none

`include "usb_mem_settings.svh"

package usb_mem_pkg;

  // One byte of a USB bulk stream
  typedef logic [7:0] usb_byte_t;

  // Store word with the first stream byte in bits 7:0
  typedef logic [31:0] mem_word_t;

  // Valid lanes of a word, always filled from bit 0 upwards
  typedef logic [3:0] byte_keep_t;

  typedef logic [`USB_MEM_ADDR_BITS-1:0] store_addr_t;  // Word address in the store
  typedef logic [`USB_MEM_ADDR_BITS:0]   store_count_t; // Word count, 0 to full

endpackage

`default_nettype wire

// ==== usb_mem_settings.svh ====
`ifndef USB_MEM_SETTINGS_SVH
`define USB_MEM_SETTINGS_SVH

// Packet store depth in 32-bit words
`define USB_MEM_STORE_WORDS 512

// Store pointer width to match the depth above
`define USB_MEM_ADDR_BITS 9

// Cycles an activity LED stays lit after the last byte
`define USB_MEM_LED_STRETCH 64

`endif
